// ==== source/gfx_pkg.sv ====
// shared constants and FSM state types for the line renderer
// screen width is fixed at 448 visible pixels, buffers are 512 deep
// colour code 15 marks an empty pixel in every layer

`default_nettype none

package gfx_pkg;

    localparam logic [8:0] MAX_H  = 9'd448; // visible pixels per line
    localparam logic [3:0] TRANSP = 4'd15;  // "no pixel" colour

    // object drawer, one pass per sprite table entry
    typedef enum logic [2:0] {
        obj_idle,
        obj_read_attr,
        obj_read_code,
        obj_read_x,
        obj_fetch,
        obj_paint,
        obj_next
    } obj_state_e;

    // scroll drawer, one pass per tile column
    typedef enum logic [2:0] {
        scr_idle,
        scr_read_map,
        scr_fetch,
        scr_paint,
        scr_next
    } scr_state_e;

    typedef enum logic [1:0] {
        mix_idle,
        mix_wait_layers, // one drawer has finished
        mix_scan,
        mix_flush        // read pipeline draining
    } mix_state_e;

endpackage

`default_nettype wire

// ==== source/line_buffer.sv ====
// 512 x 9 line memory, read data registered one cycle after rd
// words never written since reset read back as palette 0, colour TRANSP
// CLEAR_ON_READ empties each read word in the following cycle,
// a drawer write to that word in the same cycle wins

`timescale 1ns/100ps
`default_nettype none

module line_buffer
    import gfx_pkg::*;
#(
    parameter bit CLEAR_ON_READ = 1'b0
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       wr,
    input  wire logic [8:0] waddr,
    input  wire logic [8:0] wdata,
    input  wire logic [8:0] raddr,
    input  wire logic       rd,
    output logic      [8:0] rdata
);

    logic [8:0]   mem [512];
    logic [511:0] vld;      // one flag per word, cleared by reset
    logic         clr_pend;
    logic [8:0]   clr_addr;

    always_ff @(posedge clk) begin
        if (wr) mem[waddr] <= wdata;
        if (rd) rdata <= vld[raddr] ? mem[raddr] : {5'd0, TRANSP};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld      <= '0;
            clr_pend <= 1'b0;
            clr_addr <= 9'd0;
        end else begin
            clr_pend <= rd && CLEAR_ON_READ;
            clr_addr <= raddr;
            if (clr_pend && !(wr && waddr == clr_addr))
                vld[clr_addr] <= 1'b0;
            if (wr) vld[waddr] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/obj_line_draw.sv ====
// walks OBJ_COUNT sprite table entries, 4 words each, in table order
// table data is expected one cycle after tbl_addr
// ROM request is held until obj_rom_ok, then the half is toggled
// sprites are 16 pixels wide and start at x-1, x of 0 hides the entry

`timescale 1ns/100ps
`default_nettype none

module obj_line_draw
    import gfx_pkg::*;
#(
    parameter int OBJ_COUNT = 8
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        line_start,
    output logic      [8:0]  tbl_addr,
    input  wire logic [15:0] tbl_data,
    output logic             obj_rom_cs,
    output logic      [19:0] obj_rom_addr,
    output logic             obj_rom_half,
    input  wire logic [31:0] obj_rom_data,
    input  wire logic        obj_rom_ok,
    output logic             wr,
    output logic      [8:0]  waddr,
    output logic      [8:0]  wdata,
    output logic             done
);

    localparam logic [6:0] LAST_ENTRY = 7'(OBJ_COUNT - 1);

    obj_state_e  state;
    logic [6:0]  entry;
    logic        tbl_wait;  // first cycle after a new table address
    logic [3:0]  vsub;
    logic        hflip;
    logic [4:0]  pal;
    logic [31:0] pix;       // ROM word being painted
    logic [8:0]  pos;       // next buffer address
    logic [2:0]  cnt;
    logic        second;    // second half of the sprite in progress
    logic [3:0]  col;

    // current pixel, hflip walks the word from the other end
    assign col = hflip ? {pix[24], pix[16], pix[8], pix[0]}
                       : {pix[31], pix[23], pix[15], pix[7]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= obj_idle;
            entry        <= 7'd0;
            tbl_addr     <= 9'd0;
            tbl_wait     <= 1'b0;
            vsub         <= 4'd0;
            hflip        <= 1'b0;
            pal          <= 5'd0;
            pix          <= 32'd0;
            pos          <= 9'd0;
            cnt          <= 3'd0;
            second       <= 1'b0;
            obj_rom_cs   <= 1'b0;
            obj_rom_addr <= 20'd0;
            obj_rom_half <= 1'b0;
            wr           <= 1'b0;
            waddr        <= 9'd0;
            wdata        <= 9'd0;
            done         <= 1'b0;
        end else begin
            wr   <= 1'b0;
            done <= 1'b0;
            case (state)
                obj_idle: begin
                    if (line_start) begin
                        entry    <= 7'd0;
                        tbl_addr <= 9'd0;
                        tbl_wait <= 1'b1;
                        state    <= obj_read_attr;
                    end
                end
                obj_read_attr: begin
                    // address runs one word ahead of the data
                    tbl_addr[1:0] <= tbl_addr[1:0] + 2'd1;
                    tbl_wait      <= 1'b0;
                    if (!tbl_wait) begin
                        vsub  <= tbl_data[11:8];
                        hflip <= tbl_data[5];
                        pal   <= tbl_data[4:0];
                        state <= obj_read_code;
                    end
                end
                obj_read_code: begin
                    obj_rom_addr <= {tbl_data, vsub};
                    obj_rom_half <= hflip; // mirrored sprites start on the right half
                    state        <= obj_read_x;
                end
                obj_read_x: begin
                    if (tbl_data[8:0] == 9'd0) begin
                        state <= obj_next;
                    end else begin
                        pos        <= tbl_data[8:0] - 9'd1;
                        second     <= 1'b0;
                        obj_rom_cs <= 1'b1;
                        state      <= obj_fetch;
                    end
                end
                obj_fetch: begin
                    if (obj_rom_ok) begin
                        pix          <= obj_rom_data;
                        obj_rom_half <= ~obj_rom_half;
                        if (second) obj_rom_cs <= 1'b0;
                        // blank word paints a single empty pixel and jumps 8
                        if (&obj_rom_data) begin
                            cnt <= 3'd7;
                            pos <= pos + 9'd7;
                        end else begin
                            cnt <= 3'd0;
                        end
                        state <= obj_paint;
                    end
                end
                obj_paint: begin
                    wr    <= col != TRANSP;
                    waddr <= pos;
                    wdata <= {pal, col};
                    pix   <= hflip ? pix >> 1 : pix << 1;
                    pos   <= pos + 9'd1; // wraps at 512
                    cnt   <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        second <= 1'b1;
                        state  <= second ? obj_next : obj_fetch;
                    end
                end
                obj_next: begin
                    if (entry == LAST_ENTRY) begin
                        done  <= 1'b1;
                        state <= obj_idle;
                    end else begin
                        entry    <= entry + 7'd1;
                        tbl_addr <= {entry + 7'd1, 2'd0};
                        tbl_wait <= 1'b1;
                        state    <= obj_read_attr;
                    end
                end
                default: state <= obj_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/scroll_line_draw.sv ====
// paints one background tile row of MAX_H/8 + 1 tiles, 8x8 pixels each
// vpos and hscroll are sampled on line_start
// every pixel is written, transparent ones too, so no clear is needed

`timescale 1ns/100ps
`default_nettype none

module scroll_line_draw
    import gfx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        line_start,
    input  wire logic [8:0]  vpos,
    input  wire logic [8:0]  hscroll,
    output logic      [11:0] map_addr,
    input  wire logic [15:0] map_data,
    output logic             scr_rom_cs,
    output logic      [13:0] scr_rom_addr,
    input  wire logic [31:0] scr_rom_data,
    input  wire logic        scr_rom_ok,
    output logic             wr,
    output logic      [8:0]  waddr,
    output logic      [8:0]  wdata,
    output logic             done
);

    localparam logic [5:0] LAST_COL = 6'(MAX_H / 9'd8); // one extra tile for fine scroll

    scr_state_e  state;
    logic [5:0]  col_cnt;
    logic        map_wait;
    logic [2:0]  vfine;    // row inside the tile
    logic [4:0]  pal;
    logic [31:0] pix;
    logic [8:0]  pos;
    logic [2:0]  cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= scr_idle;
            col_cnt      <= 6'd0;
            map_wait     <= 1'b0;
            map_addr     <= 12'd0;
            vfine        <= 3'd0;
            pal          <= 5'd0;
            pix          <= 32'd0;
            pos          <= 9'd0;
            cnt          <= 3'd0;
            scr_rom_cs   <= 1'b0;
            scr_rom_addr <= 14'd0;
            wr           <= 1'b0;
            waddr        <= 9'd0;
            wdata        <= 9'd0;
            done         <= 1'b0;
        end else begin
            wr   <= 1'b0;
            done <= 1'b0;
            case (state)
                scr_idle: begin
                    if (line_start) begin
                        map_addr <= {vpos[8:3], hscroll[8:3]};
                        vfine    <= vpos[2:0];
                        pos      <= 9'd0 - {6'd0, hscroll[2:0]};
                        col_cnt  <= 6'd0;
                        map_wait <= 1'b1;
                        state    <= scr_read_map;
                    end
                end
                scr_read_map: begin
                    map_wait <= 1'b0;
                    if (!map_wait) begin
                        pal          <= map_data[15:11];
                        scr_rom_addr <= {map_data[10:0], vfine};
                        scr_rom_cs   <= 1'b1;
                        state        <= scr_fetch;
                    end
                end
                scr_fetch: begin
                    if (scr_rom_ok) begin
                        pix        <= scr_rom_data;
                        scr_rom_cs <= 1'b0;
                        cnt        <= 3'd0;
                        state      <= scr_paint;
                    end
                end
                scr_paint: begin
                    wr    <= 1'b1;
                    waddr <= pos;
                    wdata <= {pal, pix[31], pix[23], pix[15], pix[7]};
                    pix   <= pix << 1;
                    pos   <= pos + 9'd1;
                    cnt   <= cnt + 3'd1;
                    if (cnt == 3'd7) state <= scr_next;
                end
                scr_next: begin
                    if (col_cnt == LAST_COL) begin
                        done  <= 1'b1;
                        state <= scr_idle;
                    end else begin
                        col_cnt       <= col_cnt + 6'd1;
                        map_addr[5:0] <= map_addr[5:0] + 6'd1; // map is 64 tiles wide
                        map_wait      <= 1'b1;
                        state         <= scr_read_map;
                    end
                end
                default: state <= scr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/layer_mixer.sv ====
// waits for both done pulses, in any order, then reads both buffers
// first pixel leaves 2 cycles after the scan starts, then MAX_H in a row
// a non-transparent object pixel wins and sets bit 9 of pix_data

`timescale 1ns/100ps
`default_nettype none

module layer_mixer
    import gfx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       obj_done,
    input  wire logic       scr_done,
    output logic      [8:0] raddr,
    output logic            rd,
    input  wire logic [8:0] obj_rdata,
    input  wire logic [8:0] scr_rdata,
    output logic            pix_valid,
    output logic      [8:0] pix_x,
    output logic      [9:0] pix_data,
    output logic            line_done
);

    mix_state_e state;
    logic       obj_seen;
    logic       scr_seen;
    logic       both;
    logic       rd_q;      // buffer data valid this cycle
    logic [8:0] x_q;

    assign both = (obj_seen | obj_done) & (scr_seen | scr_done);
    assign rd   = state == mix_scan;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= mix_idle;
            obj_seen  <= 1'b0;
            scr_seen  <= 1'b0;
            raddr     <= 9'd0;
            rd_q      <= 1'b0;
            pix_valid <= 1'b0;
            line_done <= 1'b0;
        end else begin
            obj_seen  <= obj_seen | obj_done;
            scr_seen  <= scr_seen | scr_done;
            rd_q      <= rd;
            pix_valid <= rd_q;
            line_done <= pix_valid & ~rd_q; // right after the last pixel
            case (state)
                mix_idle, mix_wait_layers: begin
                    if (both) begin
                        obj_seen <= 1'b0;
                        scr_seen <= 1'b0;
                        raddr    <= 9'd0;
                        state    <= mix_scan;
                    end else if (obj_done || scr_done) begin
                        state <= mix_wait_layers;
                    end
                end
                mix_scan: begin
                    raddr <= raddr + 9'd1;
                    if (raddr == MAX_H - 9'd1) state <= mix_flush;
                end
                mix_flush: if (pix_valid && !rd_q) state <= mix_idle;
                default: state <= mix_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        x_q   <= raddr;
        pix_x <= x_q;
        if (obj_rdata[3:0] != TRANSP) pix_data <= {1'b1, obj_rdata};
        else                          pix_data <= {1'b0, scr_rdata};
    end

endmodule

`default_nettype wire

// ==== source/line_render_top.sv ====
// one scan line: object and scroll drawers run in parallel into their
// own buffers, the mixer reads both once both drawers are done
// line_start is only legal while idle, after reset or after line_done

`timescale 1ns/100ps
`default_nettype none

module line_render_top #(
    parameter int OBJ_COUNT = 8 // 1 to 128 table entries
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        line_start,
    input  wire logic [8:0]  vpos,
    input  wire logic [8:0]  hscroll,
    output logic      [8:0]  tbl_addr,
    input  wire logic [15:0] tbl_data,
    output logic             obj_rom_cs,
    output logic      [19:0] obj_rom_addr,
    output logic             obj_rom_half,
    input  wire logic [31:0] obj_rom_data,
    input  wire logic        obj_rom_ok,
    output logic      [11:0] map_addr,
    input  wire logic [15:0] map_data,
    output logic             scr_rom_cs,
    output logic      [13:0] scr_rom_addr,
    input  wire logic [31:0] scr_rom_data,
    input  wire logic        scr_rom_ok,
    output logic             pix_valid,
    output logic      [8:0]  pix_x,
    output logic      [9:0]  pix_data,
    output logic             line_done
);

    logic       obj_wr, scr_wr;
    logic [8:0] obj_waddr, scr_waddr;
    logic [8:0] obj_wdata, scr_wdata;
    logic       obj_done, scr_done;
    logic [8:0] raddr;
    logic       rd;
    logic [8:0] obj_rdata, scr_rdata;

    obj_line_draw #(.OBJ_COUNT(OBJ_COUNT)) u_obj_draw (
        .clk, .rst, .line_start,
        .tbl_addr, .tbl_data,
        .obj_rom_cs, .obj_rom_addr, .obj_rom_half, .obj_rom_data, .obj_rom_ok,
        .wr(obj_wr), .waddr(obj_waddr), .wdata(obj_wdata), .done(obj_done)
    );

    scroll_line_draw u_scr_draw (
        .clk, .rst, .line_start, .vpos, .hscroll,
        .map_addr, .map_data,
        .scr_rom_cs, .scr_rom_addr, .scr_rom_data, .scr_rom_ok,
        .wr(scr_wr), .waddr(scr_waddr), .wdata(scr_wdata), .done(scr_done)
    );

    // object buffer empties itself as the mixer reads it
    line_buffer #(.CLEAR_ON_READ(1'b1)) u_obj_buf (
        .clk, .rst, .wr(obj_wr), .waddr(obj_waddr), .wdata(obj_wdata),
        .raddr, .rd, .rdata(obj_rdata)
    );

    line_buffer #(.CLEAR_ON_READ(1'b0)) u_scr_buf (
        .clk, .rst, .wr(scr_wr), .waddr(scr_waddr), .wdata(scr_wdata),
        .raddr, .rd, .rdata(scr_rdata)
    );

    layer_mixer u_mixer (
        .clk, .rst, .obj_done, .scr_done,
        .raddr, .rd, .obj_rdata, .scr_rdata,
        .pix_valid, .pix_x, .pix_data, .line_done
    );

endmodule

`default_nettype wire

// ==== sim/line_render_props.sv ====
// concurrent checks bound into line_render_top
// busy runs from line_start to line_done

`timescale 1ns/100ps
`default_nettype none

module line_render_props (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        line_start,
    input wire logic        line_done,
    input wire logic        pix_valid,
    input wire logic        obj_rom_cs,
    input wire logic        obj_rom_ok,
    input wire logic [19:0] obj_rom_addr,
    input wire logic        obj_rom_half,
    input wire logic        scr_rom_cs,
    input wire logic        scr_rom_ok,
    input wire logic [13:0] scr_rom_addr
);

    logic busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) busy <= 1'b0;
        else if (line_start) busy <= 1'b1;
        else if (line_done) busy <= 1'b0;
    end

    start_idle: assert property (@(posedge clk) disable iff (rst) line_start |-> !busy)
        else $error("line_start while a line is in progress");

    obj_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (obj_rom_cs && !obj_rom_ok) |=> ($stable(obj_rom_addr) && $stable(obj_rom_half)))
        else $error("object ROM address moved during a stall");

    scr_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (scr_rom_cs && !scr_rom_ok) |=> $stable(scr_rom_addr))
        else $error("scroll ROM address moved during a stall");

    // covers reset too, busy is cleared there
    no_pix_idle: assert property (@(posedge clk) !busy |-> !pix_valid)
        else $error("pix_valid high outside a line or during reset");

endmodule

bind line_render_top line_render_props i_props (.*);

`default_nettype wire

// ==== sim/tb_line_render.sv ====
// random lines against a pixel model, OBJ_COUNT left at 8
// sprite codes kept to 6 bits and tile codes to 7 so the ROM arrays stay small
// table, map and both ROMs are modelled here

`timescale 1ns/100ps
`default_nettype none

module tb_line_render;
    import gfx_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        line_start;
    logic [8:0]  vpos, hscroll;
    logic [8:0]  tbl_addr;
    logic [15:0] tbl_data = 16'd0;
    logic        obj_rom_cs, obj_rom_half;
    logic        obj_rom_ok = 1'b0;
    logic [19:0] obj_rom_addr;
    logic [31:0] obj_rom_data = 32'd0;
    logic [11:0] map_addr;
    logic [15:0] map_data = 16'd0;
    logic        scr_rom_cs;
    logic        scr_rom_ok = 1'b0;
    logic [13:0] scr_rom_addr;
    logic [31:0] scr_rom_data = 32'd0;
    logic        pix_valid, line_done;
    logic [8:0]  pix_x;
    logic [9:0]  pix_data;

    logic [15:0] lfsr = 16'd15;
    logic [15:0] tbl_mem [512];
    logic [15:0] map_mem [4096];
    logic [31:0] obj_rom [2048];  // {code[5:0], vsub, half}
    logic [31:0] scr_rom [1024];  // {code[6:0], row}
    logic [2:0]  obj_wait, scr_wait;
    logic [8:0]  obj_line [512];
    logic        obj_set [512];
    logic [8:0]  scr_line [512];
    logic [9:0]  exp_pix [448];

    line_render_top i_line_render_top (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic logic [31:0] rom_word();
        logic [31:0] w;
        int j;
        w = rand_bits(32);
        if (rand_bits(3) == 0) begin
            w = '1; // blank word
        end else if (rand_bits(2) == 0) begin
            j = int'(rand_bits(3));
            w[31-j] = 1'b1;
            w[23-j] = 1'b1;
            w[15-j] = 1'b1;
            w[7-j]  = 1'b1;
        end
        return w;
    endfunction

    function automatic logic [3:0] pixel(input logic [31:0] w, input int n);
        return {w[31-n], w[23-n], w[15-n], w[7-n]};
    endfunction

    // memories answer one cycle after the address
    always @(posedge clk) begin
        tbl_data <= tbl_mem[tbl_addr];
        map_data <= map_mem[map_addr];
    end

    // ROM models raise ok for one cycle after a random delay
    always @(posedge clk) begin
        if (rst) begin
            obj_rom_ok <= 1'b0;
            obj_wait   <= 3'd0;
        end else if (obj_rom_ok) begin
            obj_rom_ok <= 1'b0;
            obj_wait   <= 3'(rand_bits(3));
        end else if (obj_rom_cs) begin
            if (obj_wait == 3'd0) begin
                obj_rom_ok   <= 1'b1;
                obj_rom_data <= obj_rom[{obj_rom_addr[9:0], obj_rom_half}];
            end else begin
                obj_wait <= obj_wait - 3'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            scr_rom_ok <= 1'b0;
            scr_wait   <= 3'd0;
        end else if (scr_rom_ok) begin
            scr_rom_ok <= 1'b0;
            scr_wait   <= 3'(rand_bits(3));
        end else if (scr_rom_cs) begin
            if (scr_wait == 3'd0) begin
                scr_rom_ok   <= 1'b1;
                scr_rom_data <= scr_rom[scr_rom_addr[9:0]];
            end else begin
                scr_wait <= scr_wait - 3'd1;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, act, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic timeout(input string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic new_line_data();
        logic [15:0] xw;
        for (int e = 0; e < 8; e++) begin
            xw = 16'(rand_bits(9));
            if (rand_bits(3) == 0) xw = 16'd0; // hidden entry
            if (e == 7) xw = 16'(9'd498 + 9'(rand_bits(3))); // runs past 511 into x 0
            tbl_mem[4*e]     = {4'd0, 4'(rand_bits(4)), 2'd0, 6'(rand_bits(6))};
            tbl_mem[4*e + 1] = 16'(rand_bits(6));
            tbl_mem[4*e + 2] = xw;
            tbl_mem[4*e + 3] = 16'(rand_bits(16));
        end
        for (int a = 0; a < 4096; a++) map_mem[a] = {5'(rand_bits(5)), 4'd0, 7'(rand_bits(7))};
    endtask

    // expected line from the layer rules
    task automatic build_model(input logic [8:0] vp, input logic [8:0] hs);
        logic [15:0] md, attr, code;
        logic [31:0] w;
        logic [3:0]  c;
        logic        half;
        int          xv, a, p;
        for (int i = 0; i < 512; i++) obj_set[i] = 1'b0;
        for (int k = 0; k < 57; k++) begin
            md = map_mem[{vp[8:3], 6'(int'(hs[8:3]) + k)}];
            w  = scr_rom[{md[6:0], vp[2:0]}];
            for (int j = 0; j < 8; j++) begin
                a = (8*k + j - int'(hs[2:0]) + 512) % 512;
                scr_line[a] = {md[15:11], pixel(w, j)};
            end
        end
        for (int e = 0; e < 8; e++) begin
            attr = tbl_mem[4*e];
            code = tbl_mem[4*e + 1];
            xv   = int'(tbl_mem[4*e + 2][8:0]);
            if (xv != 0) begin
                for (int s = 0; s < 2; s++) begin
                    half = attr[5] ^ s[0];
                    w    = obj_rom[{code[5:0], attr[11:8], half}];
                    if (!(&w)) begin
                        for (int j = 0; j < 8; j++) begin
                            p = attr[5] ? 7 - j : j;
                            c = pixel(w, p);
                            a = (xv - 1 + 8*s + j) % 512;
                            if (c != TRANSP) begin
                                obj_line[a] = {attr[4:0], c};
                                obj_set[a]  = 1'b1;
                            end
                        end
                    end
                end
            end
        end
        for (int x = 0; x < 448; x++) begin
            if (obj_set[x]) exp_pix[x] = {1'b1, obj_line[x]};
            else            exp_pix[x] = {1'b0, scr_line[x]};
        end
    endtask

    initial begin
        int cnt;
        rst        = 1'b1;
        line_start = 1'b0;
        vpos       = 9'd0;
        hscroll    = 9'd0;
        for (int a = 0; a < 512; a++) tbl_mem[a] = 16'd0;
        for (int a = 0; a < 4096; a++) map_mem[a] = 16'd0;
        for (int a = 0; a < 2048; a++) obj_rom[a] = rom_word();
        for (int a = 0; a < 1024; a++) scr_rom[a] = rom_word();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (6) begin // quiet until the first line
            @(negedge clk);
            check("pix_valid", 32'(pix_valid), 0);
            check("line_done", 32'(line_done), 0);
            check("obj_rom_cs", 32'(obj_rom_cs), 0);
            check("scr_rom_cs", 32'(scr_rom_cs), 0);
        end
        for (int ln = 0; ln < 6; ln++) begin
            new_line_data();
            @(posedge clk);
            vpos       <= 9'(rand_bits(9));
            hscroll    <= 9'(rand_bits(9));
            line_start <= 1'b1;
            @(posedge clk);
            line_start <= 1'b0;
            build_model(vpos, hscroll);
            cnt = 0;
            @(negedge clk);
            while (!pix_valid) begin
                @(negedge clk);
                cnt++;
                if (cnt > 8000) timeout("no pixels after line start");
            end
            for (int x = 0; x < 448; x++) begin
                check("pix_valid", 32'(pix_valid), 1);
                check("pix_x", 32'(pix_x), 32'(x));
                check("pix_data", 32'(pix_data), 32'(exp_pix[x]));
                @(negedge clk);
            end
            check("pix_valid", 32'(pix_valid), 0);
            check("line_done", 32'(line_done), 1);
            @(negedge clk);
            check("line_done", 32'(line_done), 0);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/gfx_pkg.sv
source/line_buffer.sv
source/obj_line_draw.sv
source/scroll_line_draw.sv
source/layer_mixer.sv
source/line_render_top.sv
sim/line_render_props.sv
sim/tb_line_render.sv

// ==== Makefile ====
# Verilator build and run of the line renderer testbench

TOP := tb_line_render
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
